//--- verilog.f
+incdir+source
source/dcache_pkg.sv
source/dcache_way.sv
source/dcache_ctrl.sv
source/dcache_top.sv
tests/dcache_assert.sv
tests/dcache_tb.sv

//--- tests/dcache_tb.sv
`include "dcache_cfg.svh"

module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 10;
    localparam int MEM_WORDS    = 1024;
    localparam int N_OPS        = 14;
    localparam int OP_LIMIT     = 30;
    localparam int WATCHDOG_CYC = N_OPS * 40;
    localparam logic [31:0] SEED = 32'hb39c;

    typedef struct packed {
        bit                    bd;
        bit                    b2b;
        bit                    we;
        bit                    unc;
        bit [`DC_ADDR_W-1:0]   addr;
        bit [`DC_WSTRB_W-1:0]  strb;
        bit [`DC_DATA_W-1:0]   data;
    } op_t;

    // backdoor, back-to-back with next, write, uncached, address, strobe, data
    op_t ops [N_OPS] = '{
        '{0, 0, 0, 0, 32'h0000_0104, 4'h0, 32'h0000_0000},
        '{0, 0, 0, 0, 32'h0000_0108, 4'h0, 32'h0000_0000},
        '{0, 1, 0, 0, 32'h0000_0100, 4'h0, 32'h0000_0000},
        '{0, 0, 0, 0, 32'h0000_010c, 4'h0, 32'h0000_0000},
        '{0, 0, 1, 0, 32'h0000_0104, 4'h6, 32'hdead_beef},
        '{0, 0, 0, 0, 32'h0000_0104, 4'h0, 32'h0000_0000},
        '{0, 0, 1, 0, 32'h0000_0230, 4'hf, 32'h1234_5678},
        '{0, 0, 0, 0, 32'h0000_0230, 4'h0, 32'h0000_0000},
        '{0, 0, 0, 0, 32'h0000_0348, 4'h0, 32'h0000_0000},
        '{1, 0, 1, 0, 32'h0000_0348, 4'hf, 32'hcafe_f00d},
        '{0, 0, 0, 1, 32'h0000_0348, 4'h0, 32'h0000_0000},
        '{0, 0, 0, 0, 32'h0000_0348, 4'h0, 32'h0000_0000},
        '{0, 0, 1, 1, 32'h0000_0234, 4'h3, 32'ha5a5_5a5a},
        '{0, 0, 0, 0, 32'h0000_0234, 4'h0, 32'h0000_0000}
    };

    logic                   clk;
    logic                   rst;
    logic                   req_valid_i;
    logic                   req_we_i;
    logic                   req_uncached_i;
    logic [`DC_ADDR_W-1:0]  req_addr_i;
    logic [`DC_WSTRB_W-1:0] req_wstrb_i;
    logic [`DC_DATA_W-1:0]  req_wdata_i;
    logic                   ready_o;
    logic                   data_ok_o;
    logic [`DC_DATA_W-1:0]  rdata_o;
    logic                   mem_req_o;
    dcache_pkg::mem_kind_e  mem_kind_o;
    logic [`DC_ADDR_W-1:0]  mem_addr_o;
    logic [`DC_DATA_W-1:0]  mem_wdata_o;
    logic [`DC_WSTRB_W-1:0] mem_wstrb_o;
    logic                   mem_ready_i;
    logic                   mem_rvalid_i;
    logic [`DC_LINE_W-1:0]  mem_rdata_i;
    logic                   mem_bvalid_i;

    // backing memory, expected memory and a model of the resident lines
    logic [`DC_DATA_W-1:0] mem [MEM_WORDS];
    logic [`DC_DATA_W-1:0] shadow [MEM_WORDS];
    logic [`DC_DATA_W-1:0] cline [int];
    bit                    resident [int];

    logic [`DC_DATA_W-1:0] exp_data [N_OPS];
    dcache_pkg::mem_kind_e exp_kind [N_OPS];
    bit                    exp_rhit [N_OPS];
    bit                    exp_req [N_OPS];
    time                   acc_time [N_OPS];
    int                    err_start [N_OPS];

    time                   ok_time_q [$];
    logic [`DC_DATA_W-1:0] ok_data_q [$];
    dcache_pkg::mem_kind_e req_kind_q [$];

    int errors = 0;
    int tests = 0;
    int failed = 0;

    bit                    busy;
    int                    delay;
    int                    base;
    dcache_pkg::mem_kind_e pend_kind;
    logic [`DC_ADDR_W-1:0] pend_addr;
    logic [`DC_LINE_W-1:0] line_tmp;

    dcache_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [`DC_DATA_W-1:0] merge_bytes(input logic [`DC_DATA_W-1:0] old_w,
            input logic [`DC_DATA_W-1:0] new_w, input logic [`DC_WSTRB_W-1:0] strb);
        logic [`DC_DATA_W-1:0] res;
        res = old_w;
        for (int b = 0; b < `DC_WSTRB_W; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_word(input logic [`DC_DATA_W-1:0] got,
            input logic [`DC_DATA_W-1:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail t=%0t %s: got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_kind(input dcache_pkg::mem_kind_e got,
            input dcache_pkg::mem_kind_e exp, input string what);
        if (got !== exp) begin
            $display("Fail t=%0t %s: got %s, expected %s", $time, what, got.name(), exp.name());
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail t=%0t %s: got %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("Fail t=%0t %s: %0d cycles, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // memory model with random back-pressure and 1 to 6 cycles of latency
    initial begin
        void'($urandom(SEED));
        forever begin
            @(posedge clk);
            if (rst) begin
                mem_ready_i  <= 1'b0;
                mem_rvalid_i <= 1'b0;
                mem_bvalid_i <= 1'b0;
                busy = 1'b0;
            end else begin
                mem_rvalid_i <= 1'b0;
                mem_bvalid_i <= 1'b0;
                if (mem_req_o) begin
                    busy      = 1'b1;
                    delay     = $urandom_range(6, 1);
                    pend_kind = mem_kind_o;
                    pend_addr = mem_addr_o;
                    req_kind_q.push_back(mem_kind_o);
                    mem_ready_i <= 1'b0;
                    if (mem_kind_o == dcache_pkg::MK_WORD_WRITE) begin
                        mem[mem_addr_o[11:2]] = merge_bytes(mem[mem_addr_o[11:2]],
                                                            mem_wdata_o, mem_wstrb_o);
                    end
                end else if (busy) begin
                    delay--;
                    if (delay == 0) begin
                        busy = 1'b0;
                        if (pend_kind == dcache_pkg::MK_WORD_WRITE) begin
                            mem_bvalid_i <= 1'b1;
                        end else begin
                            line_tmp = '0;
                            base = {pend_addr[11:4], 2'b00};
                            if (pend_kind == dcache_pkg::MK_REFILL) begin
                                line_tmp = {mem[base+3], mem[base+2], mem[base+1], mem[base]};
                            end else begin
                                line_tmp[pend_addr[3:2]*32 +: 32] = mem[pend_addr[11:2]];
                            end
                            mem_rdata_i  <= line_tmp;
                            mem_rvalid_i <= 1'b1;
                        end
                    end
                end else begin
                    mem_ready_i <= ($urandom_range(3, 0) != 0);
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && data_ok_o) begin
            ok_time_q.push_back($time);
            ok_data_q.push_back(rdata_o);
        end
    end

    // expected result of one accepted request
    task automatic predict(input int idx);
        int  w;
        int  ln;
        bit  hit;
        w   = ops[idx].addr[11:2];
        ln  = ops[idx].addr[11:4];
        hit = !ops[idx].unc && resident.exists(ln);
        exp_rhit[idx] = hit && !ops[idx].we;
        exp_req[idx]  = !exp_rhit[idx];
        exp_data[idx] = '0;
        exp_kind[idx] = dcache_pkg::MK_REFILL;
        if (ops[idx].we) begin
            exp_kind[idx] = dcache_pkg::MK_WORD_WRITE;
            shadow[w] = merge_bytes(shadow[w], ops[idx].data, ops[idx].strb);
            if (hit) begin
                cline[w] = merge_bytes(cline[w], ops[idx].data, ops[idx].strb);
            end
        end else if (ops[idx].unc) begin
            exp_kind[idx] = dcache_pkg::MK_WORD_READ;
            exp_data[idx] = shadow[w];
        end else if (hit) begin
            exp_data[idx] = cline[w];
        end else begin
            for (int k = 0; k < 4; k++) begin
                cline[ln*4 + k] = shadow[ln*4 + k];
            end
            resident[ln]  = 1'b1;
            exp_data[idx] = shadow[w];
        end
    endtask

    task automatic issue_op(input int idx, input bit same_edge);
        int waited = 0;
        err_start[idx] = errors;
        if (!same_edge) begin
            @(posedge clk);
        end
        req_valid_i    <= 1'b1;
        req_we_i       <= ops[idx].we;
        req_uncached_i <= ops[idx].unc;
        req_addr_i     <= ops[idx].addr;
        req_wstrb_i    <= ops[idx].strb;
        req_wdata_i    <= ops[idx].data;
        @(posedge clk);
        while (!ready_o && waited < OP_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!ready_o) begin
            $display("ERROR: t=%0t test %0d was never accepted", $time, idx);
            errors++;
        end
        acc_time[idx] = $time;
        req_valid_i <= 1'b0;
        predict(idx);
        // stage 2 of a memory-bound request holds ready_o low
        if (exp_req[idx]) begin
            @(posedge clk);
            check_flag(ready_o, 1'b0, $sformatf("test %0d ready_o in stage 2", idx));
        end
    endtask

    task automatic finish_op(input int idx);
        int                    waited = 0;
        time                   ok_t;
        logic [`DC_DATA_W-1:0] got;
        string                 tag;
        tag = $sformatf("test %0d", idx);
        while (ok_time_q.size() == 0 && waited < OP_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (ok_time_q.size() == 0) begin
            $display("ERROR: t=%0t %s got no data_ok_o within %0d cycles", $time, tag, OP_LIMIT);
            errors++;
        end else begin
            ok_t = ok_time_q.pop_front();
            got  = ok_data_q.pop_front();
            check_word(got, exp_data[idx], {tag, " rdata_o"});
            if (exp_rhit[idx]) begin
                check_latency(int'((ok_t - acc_time[idx]) / CLK_PERIOD), 1, {tag, " hit latency"});
            end
            if (!exp_req[idx] && req_kind_q.size() != 0) begin
                $display("ERROR: %s sent a memory request on a read hit", tag);
                errors++;
            end else if (exp_req[idx] && req_kind_q.size() != 1) begin
                $display("ERROR: %s sent %0d memory requests instead of one", tag,
                         req_kind_q.size());
                errors++;
            end else if (exp_req[idx]) begin
                check_kind(req_kind_q[0], exp_kind[idx], {tag, " mem_kind_o"});
            end
        end
        req_kind_q.delete();
        tests++;
        if (errors != err_start[idx]) begin
            failed++;
        end
        $display("%s %s%s at %h: %s", tag, ops[idx].unc ? "uncached " : "",
                 ops[idx].we ? "write" : "read", ops[idx].addr,
                 (errors == err_start[idx]) ? "ok" : "failed");
    endtask

    initial begin
        int w;
        rst            = 1'b1;
        req_valid_i    = 1'b0;
        req_we_i       = 1'b0;
        req_uncached_i = 1'b0;
        req_addr_i     = '0;
        req_wstrb_i    = '0;
        req_wdata_i    = '0;
        mem_ready_i    = 1'b0;
        mem_rvalid_i   = 1'b0;
        mem_rdata_i    = '0;
        mem_bvalid_i   = 1'b0;
        for (int k = 0; k < MEM_WORDS; k++) begin
            mem[k]    = {4'h5, 12'(k * 4), 4'ha, 12'(k * 4)};
            shadow[k] = mem[k];
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < N_OPS; i++) begin
            if (ops[i].bd) begin
                // memory changes behind the cache
                @(negedge clk);
                w = ops[i].addr[11:2];
                mem[w]    = merge_bytes(mem[w], ops[i].data, ops[i].strb);
                shadow[w] = merge_bytes(shadow[w], ops[i].data, ops[i].strb);
                $display("test %0d backdoor write at %h: ok", i, ops[i].addr);
            end else if (ops[i].b2b) begin
                issue_op(i, 1'b0);
                issue_op(i + 1, 1'b1);
                finish_op(i);
                finish_op(i + 1);
                i++;
            end else begin
                issue_op(i, 1'b0);
                finish_op(i);
            end
        end

        for (int k = 0; k < MEM_WORDS; k++) begin
            check_word(mem[k], shadow[k], $sformatf("memory word %0d", k));
        end
        errors += UUT.u_assert.fail_count;
        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (5 + WATCHDOG_CYC) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYC);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- tests/dcache_assert.sv
`include "dcache_cfg.svh"

module dcache_assert (
    input logic                  clk,
    input logic                  rst,
    input logic                  ready_o,
    input logic                  data_ok_o,
    input logic [`DC_DATA_W-1:0] rdata_o,
    input logic                  mem_req_o,
    input logic [`DC_ADDR_W-1:0] mem_addr_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // once dropped, ready_o comes back only with the data_ok_o pulse
    ready_held_low: assert property (@(posedge clk) disable iff (rst)
        !ready_o && !data_ok_o |=> !ready_o)
    else begin
        $error("ready_o rose before the request completed");
        fail_count++;
    end

    // one transaction at a time
    single_req: assert property (@(posedge clk) disable iff (rst)
        mem_req_o |=> !mem_req_o)
    else begin
        $error("mem_req_o held for two cycles");
        fail_count++;
    end

    req_addr_known: assert property (@(posedge clk) disable iff (rst)
        mem_req_o |-> !$isunknown(mem_addr_o))
    else begin
        $error("mem_addr_o unknown during a request");
        fail_count++;
    end

    rdata_known: assert property (@(posedge clk) disable iff (rst)
        data_ok_o |-> !$isunknown(rdata_o))
    else begin
        $error("rdata_o unknown with data_ok_o");
        fail_count++;
    end

    idle_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> ready_o && !data_ok_o && !mem_req_o)
    else begin
        $error("cache not idle after reset");
        fail_count++;
    end

endmodule

bind dcache_top dcache_assert u_assert (.*);

//--- source/dcache_top.sv
`include "dcache_cfg.svh"

module dcache_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid_i,
    input  logic                    req_we_i,
    input  logic                    req_uncached_i,
    input  logic [`DC_ADDR_W-1:0]   req_addr_i,
    input  logic [`DC_WSTRB_W-1:0]  req_wstrb_i,
    input  logic [`DC_DATA_W-1:0]   req_wdata_i,
    output logic                    ready_o,
    output logic                    data_ok_o,
    output logic [`DC_DATA_W-1:0]   rdata_o,
    output logic                    mem_req_o,
    output dcache_pkg::mem_kind_e   mem_kind_o,
    output logic [`DC_ADDR_W-1:0]   mem_addr_o,
    output logic [`DC_DATA_W-1:0]   mem_wdata_o,
    output logic [`DC_WSTRB_W-1:0]  mem_wstrb_o,
    input  logic                    mem_ready_i,
    input  logic                    mem_rvalid_i,
    input  logic [`DC_LINE_W-1:0]   mem_rdata_i,
    input  logic                    mem_bvalid_i
);

    logic                    way0_hit;
    logic                    way1_hit;
    logic [`DC_LINE_W-1:0]   way0_line;
    logic [`DC_LINE_W-1:0]   way1_line;
    logic [`DC_SET_W-1:0]    rd_set;
    logic [`DC_TAG_W-1:0]    cmp_tag;
    logic [`DC_LINE_W/8-1:0] way0_wr_en;
    logic [`DC_LINE_W/8-1:0] way1_wr_en;
    logic [1:0]              wr_tag_en;
    logic [`DC_SET_W-1:0]    wr_set;
    logic [`DC_TAG_W-1:0]    wr_tag;
    logic [`DC_LINE_W-1:0]   wr_line;

    // both ways share the write bus, enables are per way
    dcache_way u_way0 (
        .clk          (clk),
        .rst          (rst),
        .rd_set_i     (rd_set),
        .tag_i        (cmp_tag),
        .wr_tag_en_i  (wr_tag_en[0]),
        .wr_byte_en_i (way0_wr_en),
        .wr_set_i     (wr_set),
        .wr_tag_i     (wr_tag),
        .wr_line_i    (wr_line),
        .hit_o        (way0_hit),
        .line_o       (way0_line)
    );

    dcache_way u_way1 (
        .clk          (clk),
        .rst          (rst),
        .rd_set_i     (rd_set),
        .tag_i        (cmp_tag),
        .wr_tag_en_i  (wr_tag_en[1]),
        .wr_byte_en_i (way1_wr_en),
        .wr_set_i     (wr_set),
        .wr_tag_i     (wr_tag),
        .wr_line_i    (wr_line),
        .hit_o        (way1_hit),
        .line_o       (way1_line)
    );

    dcache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (req_valid_i),
        .req_we_i       (req_we_i),
        .req_uncached_i (req_uncached_i),
        .req_addr_i     (req_addr_i),
        .req_wstrb_i    (req_wstrb_i),
        .req_wdata_i    (req_wdata_i),
        .ready_o        (ready_o),
        .data_ok_o      (data_ok_o),
        .rdata_o        (rdata_o),
        .way0_hit_i     (way0_hit),
        .way1_hit_i     (way1_hit),
        .way0_line_i    (way0_line),
        .way1_line_i    (way1_line),
        .rd_set_o       (rd_set),
        .cmp_tag_o      (cmp_tag),
        .way0_wr_en_o   (way0_wr_en),
        .way1_wr_en_o   (way1_wr_en),
        .wr_tag_en_o    (wr_tag_en),
        .wr_set_o       (wr_set),
        .wr_tag_o       (wr_tag),
        .wr_line_o      (wr_line),
        .mem_req_o      (mem_req_o),
        .mem_kind_o     (mem_kind_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_wstrb_o    (mem_wstrb_o),
        .mem_ready_i    (mem_ready_i),
        .mem_rvalid_i   (mem_rvalid_i),
        .mem_rdata_i    (mem_rdata_i),
        .mem_bvalid_i   (mem_bvalid_i)
    );

endmodule

//--- source/dcache_ctrl.sv
`include "dcache_cfg.svh"

module dcache_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid_i,
    input  logic                      req_we_i,
    input  logic                      req_uncached_i,
    input  logic [`DC_ADDR_W-1:0]     req_addr_i,
    input  logic [`DC_WSTRB_W-1:0]    req_wstrb_i,
    input  logic [`DC_DATA_W-1:0]     req_wdata_i,
    output logic                      ready_o,
    output logic                      data_ok_o,
    output logic [`DC_DATA_W-1:0]     rdata_o,
    input  logic                      way0_hit_i,
    input  logic                      way1_hit_i,
    input  logic [`DC_LINE_W-1:0]     way0_line_i,
    input  logic [`DC_LINE_W-1:0]     way1_line_i,
    output logic [`DC_SET_W-1:0]      rd_set_o,
    output logic [`DC_TAG_W-1:0]      cmp_tag_o,
    output logic [`DC_LINE_W/8-1:0]   way0_wr_en_o,
    output logic [`DC_LINE_W/8-1:0]   way1_wr_en_o,
    output logic [1:0]                wr_tag_en_o,
    output logic [`DC_SET_W-1:0]      wr_set_o,
    output logic [`DC_TAG_W-1:0]      wr_tag_o,
    output logic [`DC_LINE_W-1:0]     wr_line_o,
    output logic                      mem_req_o,
    output dcache_pkg::mem_kind_e     mem_kind_o,
    output logic [`DC_ADDR_W-1:0]     mem_addr_o,
    output logic [`DC_DATA_W-1:0]     mem_wdata_o,
    output logic [`DC_WSTRB_W-1:0]    mem_wstrb_o,
    input  logic                      mem_ready_i,
    input  logic                      mem_rvalid_i,
    input  logic [`DC_LINE_W-1:0]     mem_rdata_i,
    input  logic                      mem_bvalid_i
);

    dcache_pkg::ctrl_state_e state_q, state_d;
    dcache_pkg::mem_kind_e kind_q, kind_d;

    logic                   s2_valid_q;
    logic                   s2_we_q;
    logic                   s2_uncached_q;
    logic [`DC_ADDR_W-1:0]  s2_addr_q;
    logic [`DC_WSTRB_W-1:0] s2_wstrb_q;
    logic [`DC_DATA_W-1:0]  s2_wdata_q;
    logic [15:0]            lfsr_q;

    logic                    accept;
    logic                    cache_hit;
    logic                    read_hit;
    logic                    write_hit;
    logic                    mem_done;
    logic                    refill_wr;
    logic                    victim;
    logic [1:0]              s2_word;
    logic [`DC_LINE_W-1:0]   hit_line;
    logic [`DC_LINE_W/8-1:0] strb_wide;
    logic [`DC_LINE_W/8-1:0] word_byte_en;

    assign s2_word = s2_addr_q[`DC_OFFSET_W-1:2];

    // way results never overlap, so an OR merge is enough
    assign hit_line = ({`DC_LINE_W{way0_hit_i}} & way0_line_i)
                    | ({`DC_LINE_W{way1_hit_i}} & way1_line_i);

    assign cache_hit = !s2_uncached_q && (way0_hit_i || way1_hit_i);

    // stage 2 in ST_IDLE is always the first cycle after acceptance
    assign read_hit  = s2_valid_q && (state_q == dcache_pkg::ST_IDLE) && !s2_we_q && cache_hit;
    assign write_hit = s2_valid_q && (state_q == dcache_pkg::ST_IDLE) && s2_we_q && cache_hit;

    assign ready_o = (state_q == dcache_pkg::ST_IDLE) && (!s2_valid_q || read_hit);
    assign accept  = req_valid_i && ready_o;

    assign mem_done = (state_q == dcache_pkg::ST_MEM_WAIT)
                   && ((kind_q == dcache_pkg::MK_WORD_WRITE) ? mem_bvalid_i : mem_rvalid_i);

    assign data_ok_o = read_hit || mem_done;

    always_comb begin
        rdata_o = '0;
        if (read_hit) begin
            rdata_o = hit_line[{s2_word, 5'b0} +: `DC_DATA_W];
        end else if (mem_done && kind_q != dcache_pkg::MK_WORD_WRITE) begin
            rdata_o = mem_rdata_i[{s2_word, 5'b0} +: `DC_DATA_W];
        end
    end

    // stage 1 lookup, stage 2 compare
    assign rd_set_o  = req_addr_i[`DC_OFFSET_W +: `DC_SET_W];
    assign cmp_tag_o = s2_addr_q[`DC_ADDR_W-1 -: `DC_TAG_W];

    // array writes: refill of the victim way, or strobed bytes into the hit way
    assign refill_wr = mem_done && (kind_q == dcache_pkg::MK_REFILL);
    assign victim    = lfsr_q[0];

    assign strb_wide    = {{(`DC_LINE_W/8 - `DC_WSTRB_W){1'b0}}, s2_wstrb_q};
    assign word_byte_en = strb_wide << {s2_word, 2'b00};

    assign wr_tag_en_o = {refill_wr && victim, refill_wr && !victim};

    always_comb begin
        way0_wr_en_o = '0;
        way1_wr_en_o = '0;
        if (refill_wr) begin
            way0_wr_en_o = victim ? '0 : '1;
            way1_wr_en_o = victim ? '1 : '0;
        end else if (write_hit) begin
            way0_wr_en_o = way0_hit_i ? word_byte_en : '0;
            way1_wr_en_o = way1_hit_i ? word_byte_en : '0;
        end
    end

    assign wr_set_o  = s2_addr_q[`DC_OFFSET_W +: `DC_SET_W];
    assign wr_tag_o  = s2_addr_q[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign wr_line_o = refill_wr ? mem_rdata_i : {(`DC_LINE_W/`DC_DATA_W){s2_wdata_q}};

    // memory port
    assign mem_req_o   = (state_q == dcache_pkg::ST_MEM_REQ) && mem_ready_i;
    assign mem_kind_o  = kind_q;
    assign mem_addr_o  = (kind_q == dcache_pkg::MK_REFILL)
                       ? ((s2_addr_q >> `DC_SIZE_LINE) << `DC_SIZE_LINE)
                       : ((s2_addr_q >> `DC_SIZE_WORD) << `DC_SIZE_WORD);
    assign mem_wdata_o = s2_wdata_q;
    assign mem_wstrb_o = s2_wstrb_q;

    always_comb begin
        state_d = state_q;
        kind_d  = kind_q;
        case (state_q)
            dcache_pkg::ST_IDLE: begin
                // anything but a read hit goes to memory
                if (s2_valid_q && !read_hit) begin
                    state_d = dcache_pkg::ST_MEM_REQ;
                    if (s2_we_q) begin
                        kind_d = dcache_pkg::MK_WORD_WRITE;
                    end else if (s2_uncached_q) begin
                        kind_d = dcache_pkg::MK_WORD_READ;
                    end else begin
                        kind_d = dcache_pkg::MK_REFILL;
                    end
                end
            end
            dcache_pkg::ST_MEM_REQ: begin
                if (mem_ready_i) begin
                    state_d = dcache_pkg::ST_MEM_WAIT;
                end
            end
            dcache_pkg::ST_MEM_WAIT: begin
                if (mem_done) begin
                    state_d = dcache_pkg::ST_IDLE;
                end
            end
            default: begin
                state_d = dcache_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= dcache_pkg::ST_IDLE;
            kind_q     <= dcache_pkg::MK_REFILL;
            s2_valid_q <= 1'b0;
            lfsr_q     <= 16'hace1;
        end else begin
            state_q <= state_d;
            kind_q  <= kind_d;
            lfsr_q  <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
            if (accept) begin
                s2_valid_q <= 1'b1;
            end else if (data_ok_o) begin
                s2_valid_q <= 1'b0;
            end
        end
    end

    // request payload, held until the request completes
    always_ff @(posedge clk) begin
        if (accept) begin
            s2_we_q       <= req_we_i;
            s2_uncached_q <= req_uncached_i;
            s2_addr_q     <= req_addr_i;
            s2_wstrb_q    <= req_wstrb_i;
            s2_wdata_q    <= req_wdata_i;
        end
    end

endmodule

//--- source/dcache_way.sv
`include "dcache_cfg.svh"

module dcache_way (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`DC_SET_W-1:0]     rd_set_i,
    input  logic [`DC_TAG_W-1:0]     tag_i,
    input  logic                     wr_tag_en_i,
    input  logic [`DC_LINE_W/8-1:0]  wr_byte_en_i,
    input  logic [`DC_SET_W-1:0]     wr_set_i,
    input  logic [`DC_TAG_W-1:0]     wr_tag_i,
    input  logic [`DC_LINE_W-1:0]    wr_line_i,
    output logic                     hit_o,
    output logic [`DC_LINE_W-1:0]    line_o
);

    logic [2**`DC_SET_W-1:0] valid_q;
    logic [`DC_TAG_W-1:0] tag_mem [2**`DC_SET_W];
    logic [`DC_LINE_W/8-1:0][7:0] data_mem [2**`DC_SET_W];

    logic rd_valid_q;
    logic [`DC_TAG_W-1:0] rd_tag_q;

    // valid bits, cleared on reset and set by a refill
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_tag_en_i) begin
            valid_q[wr_set_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_tag_en_i) begin
            tag_mem[wr_set_i] <= wr_tag_i;
        end
    end

    // byte-writable line storage
    always_ff @(posedge clk) begin
        for (int b = 0; b < `DC_LINE_W / 8; b++) begin
            if (wr_byte_en_i[b]) begin
                data_mem[wr_set_i][b] <= wr_line_i[b*8 +: 8];
            end
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= valid_q[rd_set_i];
        end
    end

    always_ff @(posedge clk) begin
        rd_tag_q <= tag_mem[rd_set_i];
        line_o   <= data_mem[rd_set_i];
    end

    // compare against the tag held in stage 2
    assign hit_o = rd_valid_q && (rd_tag_q == tag_i);

endmodule

//--- source/dcache_pkg.sv
package dcache_pkg;

    // controller FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MEM_REQ,
        ST_MEM_WAIT
    } ctrl_state_e;

    // memory transaction in progress
    typedef enum logic [1:0] {
        MK_REFILL,
        MK_WORD_READ,
        MK_WORD_WRITE
    } mem_kind_e;

endpackage

//--- source/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// address and data geometry
`define DC_ADDR_W   32
`define DC_DATA_W   32
`define DC_WSTRB_W  4

// one line holds four words
`define DC_LINE_W   128
`define DC_OFFSET_W 4

// 64 sets, the tag is what remains above index and offset
`define DC_SET_W    6
`define DC_TAG_W    22

// memory size codes, log2 of the transfer size in bytes
`define DC_SIZE_LINE 4
`define DC_SIZE_WORD 2

`endif
